/* hw/rs_enc_pkg.sv */
// Reed-Solomon encoder package with GF(2^8) symbol type, state encoding and field arithmetic
package rs_enc_pkg;

	// --------------------
	// Field definition
	// --------------------

	localparam int SYM_W = 8;

	typedef logic [SYM_W-1:0] sym_t;

	// Primitive polynomial x^8 + x^4 + x^3 + x^2 + 1, alpha = 2
	localparam logic [SYM_W:0] FIELD_POLY = 9'h11D;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_MSG    = 2'd1,
		ST_PARITY = 2'd2
	} enc_state_t;

	// --------------------
	// Field arithmetic
	// --------------------

	// Shift-and-add product, reduced modulo the field polynomial on every step
	function automatic sym_t gf_mul(input sym_t a, input sym_t b);
		sym_t prod;
		sym_t m;
		prod = '0;
		m = a;
		for (int i = 0; i < SYM_W; i++)
		begin
			if (b[i])
				prod = prod ^ m;
			if (m[SYM_W-1])
				m = {m[SYM_W-2:0], 1'b0} ^ FIELD_POLY[SYM_W-1:0];
			else
				m = {m[SYM_W-2:0], 1'b0};
		end
		return prod;
	endfunction

	// Coefficient j of g(x) = (x + a^0)(x + a^1)...(x + a^(npar-1))
	// The leading coefficient is 1 and is never requested
	function automatic sym_t gen_coef(input int npar, input int j);
		sym_t g [0:255];
		sym_t root;
		for (int k = 0; k < 256; k++)
			g[k] = '0;
		g[0] = sym_t'(1);
		root = sym_t'(1);
		for (int i = 0; i < npar; i++)
		begin
			// Multiply the running product by (x + root), top term first
			for (int k = i + 1; k > 0; k--)
				g[k] = g[k-1] ^ gf_mul(g[k], root);
			g[0] = gf_mul(g[0], root);
			root = gf_mul(root, sym_t'(2));
		end
		return g[j];
	endfunction

endpackage

/* hw/rs_enc_ctrl.sv */
// Block controller that counts message symbols and sequences the parity phase
`timescale 1ns/100ps

module rs_enc_ctrl #(
	parameter int NPAR    = 16,
	parameter int MSG_LEN = 239
) (
	input  logic                   clk,
	input  logic                   clrn,
	input  logic                   in_valid,
	output logic                   absorb,
	output logic                   shift,
	output logic                   tag_first,
	output logic                   tag_last,
	output logic                   drop,
	output rs_enc_pkg::enc_state_t state
);

	// One counter serves both phases, so it is sized for the whole codeword
	localparam int CNT_W = $clog2(MSG_LEN + NPAR + 1);

	localparam logic [CNT_W-1:0] MSG_END = CNT_W'(MSG_LEN - 1);
	localparam logic [CNT_W-1:0] PAR_END = CNT_W'(NPAR - 1);

	logic [CNT_W-1:0] count;

	// --------------------
	// Phase decode
	// --------------------

	// Strobes are taken in idle or message state, never while parity goes out
	assign absorb = in_valid &&
		(state == rs_enc_pkg::ST_IDLE || state == rs_enc_pkg::ST_MSG);
	assign shift = (state == rs_enc_pkg::ST_PARITY);

	// Count is zero in idle, so the first absorb of a block is seen here
	assign tag_first = absorb && (count == '0);
	assign tag_last  = shift && (count == PAR_END);

	// --------------------
	// State and counter
	// --------------------

	always_ff @(posedge clk or negedge clrn)
	begin
		if (!clrn)
		begin
			state <= rs_enc_pkg::ST_IDLE;
			count <= '0;
			drop  <= 1'b0;
		end
		else
		begin
			drop <= in_valid && (state == rs_enc_pkg::ST_PARITY);
			case (state)
				rs_enc_pkg::ST_IDLE, rs_enc_pkg::ST_MSG:
				begin
					if (absorb)
					begin
						// With MSG_LEN of 1 the idle state jumps straight to parity
						if (count == MSG_END)
						begin
							state <= rs_enc_pkg::ST_PARITY;
							count <= '0;
						end
						else
						begin
							state <= rs_enc_pkg::ST_MSG;
							count <= count + 1'b1;
						end
					end
				end
				rs_enc_pkg::ST_PARITY:
				begin
					if (count == PAR_END)
					begin
						state <= rs_enc_pkg::ST_IDLE;
						count <= '0;
					end
					else
						count <= count + 1'b1;
				end
				default:
				begin
					state <= rs_enc_pkg::ST_IDLE;
					count <= '0;
				end
			endcase
		end
	end

endmodule

/* hw/rs_parity_lfsr.sv */
// Parity LFSR that divides the message by the generator polynomial and shifts out the remainder
`timescale 1ns/100ps

module rs_parity_lfsr #(
	parameter int NPAR = 16
) (
	input  logic             clk,
	input  logic             clrn,
	input  logic             absorb,
	input  logic             shift,
	input  rs_enc_pkg::sym_t in_sym,
	output rs_enc_pkg::sym_t parity_sym
);

	rs_enc_pkg::sym_t par_q [NPAR];
	rs_enc_pkg::sym_t scaled [NPAR];
	rs_enc_pkg::sym_t feedback;

	// Zero feedback during shift-out turns the divider into a plain shift register
	assign feedback = absorb ? (in_sym ^ par_q[NPAR-1]) : '0;

	// --------------------
	// Constant multipliers
	// --------------------

	for (genvar j = 0; j < NPAR; j++)
	begin : g_tap
		localparam rs_enc_pkg::sym_t COEF = rs_enc_pkg::gen_coef(NPAR, j);

		assign scaled[j] = rs_enc_pkg::gf_mul(COEF, feedback);
	end

	// --------------------
	// Remainder registers
	// --------------------

	always_ff @(posedge clk or negedge clrn)
	begin
		if (!clrn)
		begin
			for (int j = 0; j < NPAR; j++)
				par_q[j] <= '0;
		end
		else if (absorb || shift)
		begin
			par_q[0] <= scaled[0];
			for (int j = 1; j < NPAR; j++)
				par_q[j] <= par_q[j-1] ^ scaled[j];
		end
	end

	// Highest-degree remainder term leaves first
	assign parity_sym = par_q[NPAR-1];

endmodule

/* hw/rs_out_stage.sv */
// Output register that selects message or parity symbol and carries the block markers
`timescale 1ns/100ps

module rs_out_stage (
	input  logic             clk,
	input  logic             clrn,
	input  logic             absorb,
	input  logic             shift,
	input  logic             tag_first,
	input  logic             tag_last,
	input  rs_enc_pkg::sym_t in_sym,
	input  rs_enc_pkg::sym_t parity_sym,
	output logic             out_valid,
	output rs_enc_pkg::sym_t out_sym,
	output logic             out_first,
	output logic             out_last
);

	// Flags follow the controller every cycle
	always_ff @(posedge clk or negedge clrn)
	begin
		if (!clrn)
		begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_last  <= 1'b0;
		end
		else
		begin
			out_valid <= absorb || shift;
			out_first <= tag_first;
			out_last  <= tag_last;
		end
	end

	// Symbol register only loads when something is sent
	always_ff @(posedge clk)
	begin
		if (absorb)
			out_sym <= in_sym;
		else if (shift)
			out_sym <= parity_sym;
	end

endmodule

/* hw/rs_enc_top.sv */
// Reed-Solomon encoder top level joining the block controller, parity LFSR and output stage
`timescale 1ns/100ps

module rs_enc_top #(
	parameter int NPAR    = 16,
	parameter int MSG_LEN = 239
) (
	input  logic             clk,
	input  logic             clrn,
	input  logic             in_valid,
	input  rs_enc_pkg::sym_t in_sym,
	output logic             out_valid,
	output rs_enc_pkg::sym_t out_sym,
	output logic             out_first,
	output logic             out_last,
	output logic             drop
);

	// MSG_LEN + NPAR must not exceed 255 symbols per codeword

	logic                   absorb;
	logic                   shift;
	logic                   tag_first;
	logic                   tag_last;
	rs_enc_pkg::sym_t       parity_sym;
	rs_enc_pkg::enc_state_t state;

	rs_enc_ctrl #(
		.NPAR    (NPAR),
		.MSG_LEN (MSG_LEN)
	) u_ctrl (
		.clk       (clk),
		.clrn      (clrn),
		.in_valid  (in_valid),
		.absorb    (absorb),
		.shift     (shift),
		.tag_first (tag_first),
		.tag_last  (tag_last),
		.drop      (drop),
		.state     (state)
	);

	rs_parity_lfsr #(
		.NPAR (NPAR)
	) u_lfsr (
		.clk        (clk),
		.clrn       (clrn),
		.absorb     (absorb),
		.shift      (shift),
		.in_sym     (in_sym),
		.parity_sym (parity_sym)
	);

	rs_out_stage u_out (
		.clk        (clk),
		.clrn       (clrn),
		.absorb     (absorb),
		.shift      (shift),
		.tag_first  (tag_first),
		.tag_last   (tag_last),
		.in_sym     (in_sym),
		.parity_sym (parity_sym),
		.out_valid  (out_valid),
		.out_sym    (out_sym),
		.out_first  (out_first),
		.out_last   (out_last)
	);

endmodule

/* bench/tb_clock.sv */
// Testbench clock source, free running from time zero
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#(PERIOD / 2) clk = ~clk;

endmodule

/* bench/rs_enc_asserts.sv */
// Bound checks on parity phase length, drop timing and output marker qualification
`timescale 1ns/100ps

module rs_enc_asserts #(
	parameter int NPAR = 16
) (
	input logic                   clk,
	input logic                   clrn,
	input rs_enc_pkg::enc_state_t state,
	input logic                   drop,
	input logic                   out_valid,
	input logic                   out_first,
	input logic                   out_last
);

	logic in_par;
	int   run_len;

	assign in_par = (state == rs_enc_pkg::ST_PARITY);

	// Cycles spent so far in the current parity run
	always_ff @(posedge clk or negedge clrn)
	begin
		if (!clrn)
			run_len <= 0;
		else if (in_par)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	a_par_len: assert property (@(posedge clk) disable iff (!clrn)
		$fell(in_par) |-> run_len == NPAR)
		else $error("parity phase ended after the wrong number of cycles");

	a_par_max: assert property (@(posedge clk) disable iff (!clrn)
		in_par |-> run_len < NPAR)
		else $error("parity phase runs longer than NPAR cycles");

	a_drop: assert property (@(posedge clk) disable iff (!clrn)
		drop |-> $past(in_par))
		else $error("drop pulse without a parity cycle before it");

	a_tags: assert property (@(posedge clk) disable iff (!clrn)
		(out_first || out_last) |-> out_valid)
		else $error("block marker on the output without out_valid");

endmodule

bind rs_enc_top rs_enc_asserts #(
	.NPAR (NPAR)
) u_asserts (
	.clk       (clk),
	.clrn      (clrn),
	.state     (state),
	.drop      (drop),
	.out_valid (out_valid),
	.out_first (out_first),
	.out_last  (out_last)
);

/* bench/rs_enc_tb.sv */
// Testbench for the Reed-Solomon encoder with a division model and a table of block tests
`timescale 1ns/100ps

module rs_enc_tb;

	localparam int NPAR       = 16;
	localparam int MSG_LEN    = 20;
	localparam int NTEST      = 6;
	localparam int PERIOD     = 40;
	localparam int FILL_RAND  = 0;
	localparam int FILL_ZERO  = 1;
	localparam int FILL_COUNT = 2;
	localparam int FILL_ONE   = 3;

	logic       clk;
	logic       clrn;
	logic       in_valid;
	logic [7:0] in_sym;
	logic       out_valid;
	logic [7:0] out_sym;
	logic       out_first;
	logic       out_last;
	logic       drop;

	// Stimulus table. Gap 0 is back-to-back, gap n idles after every nth strobe, -1 is random
	string t_name [NTEST];
	int    t_fill [NTEST];
	int    t_gap  [NTEST];
	bit    t_drop [NTEST];

	logic [7:0] gpoly [NPAR+1];
	logic [7:0] msg [MSG_LEN];
	logic [7:0] cw [MSG_LEN+NPAR];
	int         sent_cyc [MSG_LEN];
	logic [7:0] rx_sym [$];
	int         rx_cyc [$];
	logic [1:0] rx_tag [$];
	int         drop_q [$];
	int         cyc;
	int         errors;
	int         checks;
	bit         last_seen;

	tb_clock #(.PERIOD(PERIOD)) u_clock (.clk(clk));

	rs_enc_top #(
		.NPAR    (NPAR),
		.MSG_LEN (MSG_LEN)
	) u_rs_enc_top (
		.clk       (clk),
		.clrn      (clrn),
		.in_valid  (in_valid),
		.in_sym    (in_sym),
		.out_valid (out_valid),
		.out_sym   (out_sym),
		.out_first (out_first),
		.out_last  (out_last),
		.drop      (drop)
	);

	// Product in GF(2^8) mod 0x11D, Horner over the bits of a from the top
	function automatic logic [7:0] field_mul(logic [7:0] a, logic [7:0] b);
		logic [7:0] acc;
		acc = 8'h00;
		for (int i = 7; i >= 0; i--)
		begin
			acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1D : 8'h00);
			if (a[i])
				acc = acc ^ b;
		end
		return acc;
	endfunction

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Error %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic add_row(int r, string name, int fill, int gap, bit with_drop);
		t_name[r] = name;
		t_fill[r] = fill;
		t_gap[r]  = gap;
		t_drop[r] = with_drop;
	endtask

	// One cycle: wait for the falling edge and log whatever the DUT shows there
	task automatic tick();
		@(negedge clk);
		cyc++;
		if (out_valid)
		begin
			rx_sym.push_back(out_sym);
			rx_cyc.push_back(cyc);
			rx_tag.push_back({out_first, out_last});
		end
		if (out_last)
			last_seen = 1'b1;
		if (drop)
			drop_q.push_back(cyc);
	endtask

	// g(x) = (x + 1)(x + a)...(x + a^(NPAR-1)), gpoly[k] is the coefficient of x^k
	task automatic make_generator();
		logic [7:0] root;
		gpoly[0] = 8'h01;
		for (int k = 1; k <= NPAR; k++)
			gpoly[k] = 8'h00;
		root = 8'h01;
		for (int i = 0; i < NPAR; i++)
		begin
			for (int k = i + 1; k > 0; k--)
				gpoly[k] = gpoly[k-1] ^ field_mul(gpoly[k], root);
			gpoly[0] = field_mul(gpoly[0], root);
			root = field_mul(root, 8'h02);
		end
	endtask

	task automatic build_message(int fill);
		for (int k = 0; k < MSG_LEN; k++)
			case (fill)
				FILL_ZERO:  msg[k] = 8'h00;
				FILL_COUNT: msg[k] = 8'(k + 1);
				FILL_ONE:   msg[k] = (k == MSG_LEN / 2) ? 8'h5A : 8'h00;
				default:    msg[k] = 8'($urandom);
			endcase
	endtask

	// Long division of msg(x) * x^NPAR by g(x), then the message goes back in front
	task automatic encode_model();
		logic [7:0] coef;
		for (int k = 0; k < MSG_LEN + NPAR; k++)
			cw[k] = (k < MSG_LEN) ? msg[k] : 8'h00;
		for (int i = 0; i < MSG_LEN; i++)
		begin
			coef = cw[i];
			for (int j = 1; j <= NPAR; j++)
				cw[i+j] = cw[i+j] ^ field_mul(coef, gpoly[NPAR-j]);
		end
		for (int k = 0; k < MSG_LEN; k++)
			cw[k] = msg[k];
	endtask

	function automatic logic [7:0] eval_at(logic [7:0] x);
		logic [7:0] s;
		s = 8'h00;
		foreach (rx_sym[k])
			s = field_mul(s, x) ^ rx_sym[k];
		return s;
	endfunction

	function automatic int idle_after(int gap, int k);
		if (gap < 0)
			return ($urandom_range(3) == 0) ? 1 : 0;
		if (gap > 0 && (k % gap) == gap - 1)
			return 1;
		return 0;
	endfunction

	task automatic run_block(int r);
		int         last_cyc;
		int         exp_cyc;
		string      nm;
		logic [7:0] x;
		rx_sym.delete();
		rx_cyc.delete();
		rx_tag.delete();
		drop_q.delete();
		last_seen = 1'b0;
		nm = t_name[r];
		build_message(t_fill[r]);
		encode_model();
		for (int k = 0; k < MSG_LEN; k++)
		begin
			tick();
			in_valid = 1'b1;
			in_sym = msg[k];
			sent_cyc[k] = cyc;
			repeat (idle_after(t_gap[r], k))
			begin
				tick();
				in_valid = 1'b0;
			end
		end
		last_cyc = sent_cyc[MSG_LEN-1];
		// Stray strobe in the third parity cycle where the row asks for one
		do
		begin
			tick();
			in_valid = t_drop[r] && (cyc == last_cyc + 3);
			in_sym = 8'($urandom);
		end
		while (!last_seen);

		// --------------------
		// Block checks
		// --------------------
		check_value({nm, " length"}, 32'(MSG_LEN + NPAR), 32'(rx_sym.size()));
		if (rx_sym.size() == MSG_LEN + NPAR)
			for (int k = 0; k < MSG_LEN + NPAR; k++)
			begin
				exp_cyc = (k < MSG_LEN) ? sent_cyc[k] + 1 : last_cyc + 2 + k - MSG_LEN;
				check_value($sformatf("%s symbol %0d", nm, k), 32'(cw[k]), 32'(rx_sym[k]));
				check_value($sformatf("%s cycle %0d", nm, k), 32'(exp_cyc), 32'(rx_cyc[k]));
				check_value($sformatf("%s tags %0d", nm, k),
					32'({k == 0, k == MSG_LEN + NPAR - 1}), 32'(rx_tag[k]));
			end
		x = 8'h01;
		for (int i = 0; i < NPAR; i++)
		begin
			check_value($sformatf("%s syndrome %0d", nm, i), 32'h0, 32'(eval_at(x)));
			x = field_mul(x, 8'h02);
		end
		check_value({nm, " drops"}, 32'(t_drop[r]), 32'(drop_q.size()));
		if (t_drop[r] && drop_q.size() == 1)
			check_value({nm, " drop cycle"}, 32'(last_cyc + 4), 32'(drop_q[0]));
	endtask

	initial
	begin
		void'($urandom(5595));
		clrn = 1'b0;
		in_valid = 1'b0;
		in_sym = 8'h00;
		cyc = 0;
		errors = 0;
		checks = 0;
		last_seen = 1'b0;
		add_row(0, "zero_msg", FILL_ZERO, 0, 1'b0);
		add_row(1, "count_b2b", FILL_COUNT, 0, 1'b0);
		add_row(2, "count_gap", FILL_COUNT, 2, 1'b0);
		add_row(3, "single_sym", FILL_ONE, 4, 1'b0);
		add_row(4, "random_drop", FILL_RAND, 0, 1'b1);
		add_row(5, "random_gap", FILL_RAND, -1, 1'b1);
		make_generator();
		repeat (4) tick();
		check_value("reset", 32'h0, 32'({out_valid, out_first, out_last, drop}));
		clrn = 1'b1;
		tick();
		check_value("after reset", 32'h0, 32'({out_valid, out_first, out_last, drop}));
		for (int r = 0; r < NTEST; r++)
			run_block(r);
		tick();
		$display("Result: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog sized from the table length and the codeword length
	initial
	begin
		#((NTEST * (MSG_LEN + NPAR + 10) + 20) * PERIOD);
		$display("Timeout: the encoder did not finish all blocks in the allowed time");
		$display("tests failed");
		$finish;
	end

endmodule

/* rs_enc_top.f */
hw/rs_enc_pkg.sv
hw/rs_enc_ctrl.sv
hw/rs_parity_lfsr.sv
hw/rs_out_stage.sv
hw/rs_enc_top.sv
bench/tb_clock.sv
bench/rs_enc_asserts.sv
bench/rs_enc_tb.sv

/* run.sh */
#!/bin/sh
# Build the encoder testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f rs_enc_top.f --top-module rs_enc_tb -o rs_enc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rs_enc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0
